// ==== exec_defs.svh ====
`ifndef EXEC_DEFS_SVH
`define EXEC_DEFS_SVH

`define DATA_W  16 // Datapath width
`define REG_CNT 8  // Architectural registers
`define SHAMT_W 4  // Shift amount, low bits of B

// ALU opcodes, same order as the ISA table
`define OP_ADD   4'h0 // A + B
`define OP_SUB   4'h1 // B - A
`define OP_XOR   4'h2
`define OP_ANDN  4'h3 // A & ~B
`define OP_ROL   4'h4 // First of the four shift ops
`define OP_SLL   4'h5
`define OP_ROR   4'h6
`define OP_SRL   4'h7 // Last of the four shift ops
`define OP_SEQ   4'h8 // A == B
`define OP_SLT   4'h9 // Signed A < B
`define OP_SLE   4'ha // Signed A <= B
`define OP_SCO   4'hb // Carry out of A + B
`define OP_BTR   4'hc // Bit reverse of A
`define OP_PASSB 4'hd
`define OP_SLBI  4'he // A low byte over B low byte
`define OP_PC2   4'hf

`endif

// ==== alu_pkg.sv ====
`default_nettype none

`include "exec_defs.svh"

// Data side types of the execute unit
package alu_pkg;

	typedef logic [`DATA_W-1:0] data_t; // Operand, result, register word

	typedef logic [`SHAMT_W-1:0] shamt_t; // Shift or rotate distance

	typedef logic [3:0] alu_op_t; // One of sixteen ALU functions

endpackage

`default_nettype wire

// ==== exec_pkg.sv ====
`default_nettype none

`include "exec_defs.svh"

// Control and storage types
package exec_pkg;

	typedef logic [$clog2(`REG_CNT)-1:0] reg_idx_t; // Register file address

	typedef enum logic [1:0] {
		IDLE,  // Waiting for start
		SHIFT, // One bit per cycle
		WRITE  // Write-back and done
	} exec_state_t;

endpackage

`default_nettype wire

// ==== alu_cla.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "exec_defs.svh"

module alu_cla (
	input  alu_pkg::data_t a_i,
	input  alu_pkg::data_t b_i,
	input  logic           ci_i,
	output alu_pkg::data_t s_o,
	output logic           co_o
);

	alu_pkg::data_t gen;   // Bit generate
	alu_pkg::data_t prop;  // Bit propagate
	alu_pkg::data_t carry; // Carry into each bit
	logic [3:0] grp_g;     // Group generate
	logic [3:0] grp_p;     // Group propagate
	logic [4:0] grp_c;     // Carry into each group, [4] is carry out

	assign gen  = a_i & b_i;
	assign prop = a_i ^ b_i;

	// First level, lookahead inside each nibble
	for (genvar gi = 0; gi < `DATA_W/4; gi++) begin : g_grp
		assign carry[4*gi]   = grp_c[gi];
		assign carry[4*gi+1] = gen[4*gi] | (prop[4*gi] & grp_c[gi]);
		assign carry[4*gi+2] = gen[4*gi+1] | (prop[4*gi+1] & gen[4*gi]) |
			(prop[4*gi+1] & prop[4*gi] & grp_c[gi]);
		assign carry[4*gi+3] = gen[4*gi+2] | (prop[4*gi+2] & gen[4*gi+1]) |
			(prop[4*gi+2] & prop[4*gi+1] & gen[4*gi]) |
			(prop[4*gi+2] & prop[4*gi+1] & prop[4*gi] & grp_c[gi]);
		assign grp_g[gi] = gen[4*gi+3] | (prop[4*gi+3] & gen[4*gi+2]) |
			(prop[4*gi+3] & prop[4*gi+2] & gen[4*gi+1]) |
			(prop[4*gi+3] & prop[4*gi+2] & prop[4*gi+1] & gen[4*gi]);
		assign grp_p[gi] = &prop[4*gi +: 4]; // Whole nibble propagates
	end

	// Second level, carries between nibbles
	assign grp_c[0] = ci_i;
	assign grp_c[1] = grp_g[0] | (grp_p[0] & ci_i);
	assign grp_c[2] = grp_g[1] | (grp_p[1] & grp_g[0]) | (grp_p[1] & grp_p[0] & ci_i);
	assign grp_c[3] = grp_g[2] | (grp_p[2] & grp_g[1]) | (grp_p[2] & grp_p[1] & grp_g[0]) |
		(grp_p[2] & grp_p[1] & grp_p[0] & ci_i);
	assign grp_c[4] = grp_g[3] | (grp_p[3] & grp_g[2]) | (grp_p[3] & grp_p[2] & grp_g[1]) |
		(grp_p[3] & grp_p[2] & grp_p[1] & grp_g[0]) |
		(grp_p[3] & grp_p[2] & grp_p[1] & grp_p[0] & ci_i);

	assign s_o  = prop ^ carry;
	assign co_o = grp_c[4]; // Carry out of the top nibble

endmodule

`default_nettype wire

// ==== shift_counter.sv ====
`timescale 1ns/10ps
`default_nettype none

module shift_counter (
	input  logic            clk,
	input  logic            arst_n_i,
	input  logic            load_i,   // Operand capture
	input  alu_pkg::shamt_t cnt_i,    // Low bits of B
	input  logic            dec_i,    // One shift step taken
	output logic            zero_o    // No steps left after this edge
);

	alu_pkg::shamt_t cnt_q; // Steps still to do
	alu_pkg::shamt_t cnt_d;

	always_comb begin
		cnt_d = cnt_q; // Hold by default
		if (load_i) begin
			cnt_d = cnt_i;
		end else if (dec_i && (cnt_q != '0)) begin
			cnt_d = cnt_q - 1'b1; // Never wraps below zero
		end
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			cnt_q <= '0;
		end else begin
			cnt_q <= cnt_d;
		end
	end

	// Looks at the next count, so the FSM leaves SHIFT on the last step
	// and can skip SHIFT entirely for a zero distance
	assign zero_o = (cnt_d == '0);

endmodule

`default_nettype wire

// ==== alu_shifter.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "exec_defs.svh"

module alu_shifter (
	input  logic           clk,
	input  logic           arst_n_i,
	input  logic           load_i,   // Take A
	input  logic           step_i,   // Move one bit
	input  alu_pkg::data_t data_i,
	input  logic [1:0]     mode_i,   // [1] right, [0] zero fill
	output alu_pkg::data_t data_o
);

	alu_pkg::data_t sh_q;
	alu_pkg::data_t sh_nxt; // Value after one step

	always_comb begin
		case (mode_i)
			2'b00: sh_nxt = {sh_q[`DATA_W-2:0], sh_q[`DATA_W-1]}; // Rotate left
			2'b01: sh_nxt = {sh_q[`DATA_W-2:0], 1'b0};            // Shift left
			2'b10: sh_nxt = {sh_q[0], sh_q[`DATA_W-1:1]};         // Rotate right
			default: begin
				sh_nxt = {1'b0, sh_q[`DATA_W-1:1]}; // Logical shift right
			end
		endcase
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			sh_q <= '0;
		end else if (load_i) begin
			sh_q <= data_i; // Load wins over step
		end else if (step_i) begin
			sh_q <= sh_nxt;
		end
	end

	assign data_o = sh_q;

endmodule

`default_nettype wire

// ==== alu.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "exec_defs.svh"

module alu (
	input  logic              clk,
	input  logic              arst_n_i,
	input  logic              cap_i,    // Capture A and B
	input  alu_pkg::alu_op_t  op_i,     // Captured opcode
	input  alu_pkg::data_t    a_i,
	input  alu_pkg::data_t    b_i,
	input  alu_pkg::data_t    shift_i,  // Shifter register
	input  alu_pkg::data_t    pc2_i,
	output alu_pkg::data_t    result_o,
	output logic              lt_o,
	output logic              zf_o
);

	alu_pkg::data_t a_q;     // Operand copies, stable while shifting
	alu_pkg::data_t b_q;
	alu_pkg::data_t cla_a;
	alu_pkg::data_t cla_b;
	logic           cla_ci;
	alu_pkg::data_t cla_s;
	logic           cla_co;
	alu_pkg::data_t rev;     // A bit reversed
	alu_pkg::data_t res;
	logic           slt;     // Signed A < B
	logic           eq;

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			a_q <= '0;
			b_q <= '0;
		end else if (cap_i) begin
			a_q <= a_i;
			b_q <= b_i;
		end
	end

	// Adder operand steering
	always_comb begin
		cla_a  = a_q;
		cla_b  = b_q;
		cla_ci = 1'b0; // Plain A + B for add and carry out
		case (op_i)
			`OP_SUB: begin
				cla_a  = b_q;  // B - A
				cla_b  = ~a_q;
				cla_ci = 1'b1;
			end
			`OP_SLT, `OP_SLE: begin
				cla_b  = ~b_q; // A - B
				cla_ci = 1'b1;
			end
			default: begin
				cla_ci = 1'b0;
			end
		endcase
	end

	alu_cla u_cla (
		.a_i  (cla_a),
		.b_i  (cla_b),
		.ci_i (cla_ci),
		.s_o  (cla_s),
		.co_o (cla_co)
	);

	always_comb begin
		for (int i = 0; i < `DATA_W; i++) begin
			rev[i] = a_q[`DATA_W-1-i];
		end
	end

	assign eq = (a_q == b_q);
	// Signs differ, so the negative one is smaller; else difference sign, no overflow
	assign slt = (a_q[`DATA_W-1] != b_q[`DATA_W-1]) ? a_q[`DATA_W-1] : cla_s[`DATA_W-1];

	always_comb begin
		res = '0;
		case (op_i)
			`OP_ADD, `OP_SUB: res = cla_s;
			`OP_XOR:          res = a_q ^ b_q;
			`OP_ANDN:         res = a_q & ~b_q;
			`OP_ROL, `OP_SLL, `OP_ROR, `OP_SRL: res = shift_i; // Already stepped
			`OP_SEQ:          res = {{(`DATA_W-1){1'b0}}, eq};
			`OP_SLT:          res = {{(`DATA_W-1){1'b0}}, slt};
			`OP_SLE:          res = {{(`DATA_W-1){1'b0}}, slt | eq};
			`OP_SCO:          res = {{(`DATA_W-1){1'b0}}, cla_co};
			`OP_BTR:          res = rev;
			`OP_PASSB:        res = b_q;
			`OP_SLBI:         res = {a_q[7:0], b_q[7:0]};
			`OP_PC2:          res = pc2_i;
			default:          res = '0;
		endcase
	end

	assign result_o = res;
	assign zf_o     = (res == '0);
	assign lt_o     = ((op_i == `OP_SLT) || (op_i == `OP_SLE)) ? slt : 1'b0; // Compares only

endmodule

`default_nettype wire

// ==== reg_file.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "exec_defs.svh"

module reg_file (
	input  logic              clk,
	input  logic              arst_n_i,
	input  logic              we_i,
	input  exec_pkg::reg_idx_t waddr_i,
	input  alu_pkg::data_t    wdata_i,
	input  exec_pkg::reg_idx_t raddr_a_i, // rs
	input  exec_pkg::reg_idx_t raddr_b_i, // rt
	output alu_pkg::data_t    rdata_a_o,
	output alu_pkg::data_t    rdata_b_o
);

	alu_pkg::data_t regs [`REG_CNT];

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 0; i < `REG_CNT; i++) begin
				regs[i] <= '0; // All registers read zero after reset
			end
		end else if (we_i) begin
			regs[waddr_i] <= wdata_i;
		end
	end

	// No write bypass, a write shows up the next cycle
	assign rdata_a_o = regs[raddr_a_i];
	assign rdata_b_o = regs[raddr_b_i];

endmodule

`default_nettype wire

// ==== exec_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "exec_defs.svh"

module exec_ctrl (
	input  logic               clk,
	input  logic               arst_n_i,
	input  logic               start_i,
	input  alu_pkg::alu_op_t   op_i,
	input  exec_pkg::reg_idx_t rd_i,
	input  logic               cnt_zero_i, // Counter hits zero at next edge
	output logic               busy_o,
	output logic               cap_o,      // Operand capture strobe
	output logic               step_o,     // Shift one bit
	output logic               wb_o,       // Register file write
	output logic               done_o,
	output exec_pkg::reg_idx_t wb_addr_o,
	output alu_pkg::alu_op_t   op_o
);

	exec_pkg::exec_state_t state_q;
	exec_pkg::exec_state_t state_d;
	alu_pkg::alu_op_t      op_q;
	exec_pkg::reg_idx_t    rd_q;
	logic                  accept;
	logic                  is_shift; // Opcodes 4 to 7

	assign accept   = (state_q == exec_pkg::IDLE) && start_i; // Dropped while busy
	assign is_shift = (op_i >= `OP_ROL) && (op_i <= `OP_SRL);

	always_comb begin
		state_d = state_q;
		case (state_q)
			exec_pkg::IDLE: begin
				if (accept) begin
					// Zero distance needs no steps
					state_d = (is_shift && !cnt_zero_i) ? exec_pkg::SHIFT : exec_pkg::WRITE;
				end
			end
			exec_pkg::SHIFT: begin
				if (cnt_zero_i) begin
					state_d = exec_pkg::WRITE; // Last step this cycle
				end
			end
			exec_pkg::WRITE: state_d = exec_pkg::IDLE;
			default:         state_d = exec_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q <= exec_pkg::IDLE;
			op_q    <= '0;
			rd_q    <= '0;
		end else begin
			state_q <= state_d;
			if (accept) begin
				op_q <= op_i;
				rd_q <= rd_i;
			end
		end
	end

	assign busy_o    = (state_q != exec_pkg::IDLE);
	assign cap_o     = accept;
	assign step_o    = (state_q == exec_pkg::SHIFT);
	assign wb_o      = (state_q == exec_pkg::WRITE);
	assign done_o    = (state_q == exec_pkg::WRITE); // Result visible this cycle
	assign wb_addr_o = rd_q;
	assign op_o      = op_q;

endmodule

`default_nettype wire

// ==== exec_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "exec_defs.svh"

module exec_top (
	input  logic               clk,
	input  logic               arst_n_i,
	input  logic               load_i,
	input  exec_pkg::reg_idx_t load_addr_i,
	input  alu_pkg::data_t     load_data_i,
	input  logic               start_i,
	input  alu_pkg::alu_op_t   op_i,
	input  exec_pkg::reg_idx_t rs_i,       // A
	input  exec_pkg::reg_idx_t rt_i,       // B
	input  exec_pkg::reg_idx_t rd_i,
	input  alu_pkg::data_t     pc2_i,
	output logic               busy_o,
	output logic               done_o,
	output alu_pkg::data_t     result_o,
	output logic               zf_o,
	output logic               lt_o
);

	logic               busy;
	logic               cap;
	logic               step;
	logic               wb;
	logic               cnt_zero;
	exec_pkg::reg_idx_t wb_addr;
	alu_pkg::alu_op_t   op_q;
	alu_pkg::data_t     rdata_a;
	alu_pkg::data_t     rdata_b;
	alu_pkg::data_t     shift_q;
	alu_pkg::data_t     alu_res;
	logic               alu_lt;
	logic               alu_zf;
	logic               rf_we;
	exec_pkg::reg_idx_t rf_waddr;
	alu_pkg::data_t     rf_wdata;
	alu_pkg::data_t     result_q; // Held between done pulses
	logic               zf_q;
	logic               lt_q;

	exec_ctrl u_ctrl (
		.clk        (clk),
		.arst_n_i   (arst_n_i),
		.start_i    (start_i),
		.op_i       (op_i),
		.rd_i       (rd_i),
		.cnt_zero_i (cnt_zero),
		.busy_o     (busy),
		.cap_o      (cap),
		.step_o     (step),
		.wb_o       (wb),
		.done_o     (done_o),
		.wb_addr_o  (wb_addr),
		.op_o       (op_q)
	);

	shift_counter u_cnt (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.load_i   (cap),
		.cnt_i    (rdata_b[`SHAMT_W-1:0]), // Distance from B
		.dec_i    (step),
		.zero_o   (cnt_zero)
	);

	alu_shifter u_shift (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.load_i   (cap),
		.step_i   (step),
		.data_i   (rdata_a),
		.mode_i   (op_q[1:0]), // Low opcode bits pick the direction and fill
		.data_o   (shift_q)
	);

	alu u_alu (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.cap_i    (cap),
		.op_i     (op_q),
		.a_i      (rdata_a),
		.b_i      (rdata_b),
		.shift_i  (shift_q),
		.pc2_i    (pc2_i),
		.result_o (alu_res),
		.lt_o     (alu_lt),
		.zf_o     (alu_zf)
	);

	// Write-back only happens while busy, outside loads only while idle
	assign rf_we    = wb | (load_i & ~busy);
	assign rf_waddr = wb ? wb_addr : load_addr_i;
	assign rf_wdata = wb ? alu_res : load_data_i;

	reg_file u_rf (
		.clk       (clk),
		.arst_n_i  (arst_n_i),
		.we_i      (rf_we),
		.waddr_i   (rf_waddr),
		.wdata_i   (rf_wdata),
		.raddr_a_i (rs_i),
		.raddr_b_i (rt_i),
		.rdata_a_o (rdata_a),
		.rdata_b_o (rdata_b)
	);

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			result_q <= '0;
			zf_q     <= 1'b0;
			lt_q     <= 1'b0;
		end else if (wb) begin
			result_q <= alu_res;
			zf_q     <= alu_zf;
			lt_q     <= alu_lt;
		end
	end

	// Live ALU values in the done cycle, registered copies after it
	assign result_o = wb ? alu_res : result_q;
	assign zf_o     = wb ? alu_zf : zf_q;
	assign lt_o     = wb ? alu_lt : lt_q;
	assign busy_o   = busy;

endmodule

`default_nettype wire

// ==== exec_chk.sv ====
`timescale 1ns/10ps
`default_nettype none

module exec_chk (
	input logic                  clk,
	input logic                  arst_n_i,
	input logic                  busy_i,
	input logic                  cap_i,
	input logic                  step_i,
	input logic                  wb_i,
	input logic                  done_i
);

	done_pulse: assert property (@(posedge clk) disable iff (!arst_n_i) done_i |=> !done_i)
		else $error("done_o high for more than one cycle");

	wb_pulse: assert property (@(posedge clk) disable iff (!arst_n_i) wb_i |=> !wb_i)
		else $error("we_o high for more than one cycle");

	// Done only while busy, right after a capture or the last step
	done_in_busy: assert property (@(posedge clk) disable iff (!arst_n_i)
		done_i |-> (busy_i && $past(cap_i || step_i)))
		else $error("done_o high while not busy or without a capture or step before it");

	// Steps start just after a capture and then run back to back
	step_in_shift: assert property (@(posedge clk) disable iff (!arst_n_i)
		step_i |-> (busy_i && $past(cap_i || step_i)))
		else $error("step_o high outside a shift sequence");

	// Everything quiet while reset is held
	reset_quiet: assert property (@(posedge clk)
		!arst_n_i |-> !(busy_i || cap_i || step_i || wb_i || done_i))
		else $error("controller output high during reset");

endmodule

`default_nettype wire

// ==== tb_exec.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "exec_defs.svh"

module tb_exec;

	localparam int CLK_HALF  = 50;
	localparam int LAT_LIMIT = 20;                 // Cycles allowed per operation
	localparam int RESET_OPS = `REG_CNT;
	localparam int ARITH_OPS = 4 * (`REG_CNT + 8 + 1);
	localparam int CMP_OPS   = 7 * (2 + 4);
	localparam int SHIFT_OPS = 4 * (1 + 2 * 16);
	localparam int BUSY_OPS  = 8;
	localparam int ZERO_OPS  = 10;
	localparam int TOTAL_OPS = RESET_OPS + ARITH_OPS + CMP_OPS + SHIFT_OPS + BUSY_OPS + ZERO_OPS;
	localparam logic [31:0] ARITH_SEQ = {`OP_ADD, `OP_SUB, `OP_XOR, `OP_ANDN,
		`OP_BTR, `OP_PASSB, `OP_SLBI, `OP_PC2}; // Nibble per opcode

	logic               clk;
	logic               arst_n_i;
	logic               load_i;
	exec_pkg::reg_idx_t load_addr_i;
	alu_pkg::data_t     load_data_i;
	logic               start_i;
	alu_pkg::alu_op_t   op_i;
	exec_pkg::reg_idx_t rs_i;
	exec_pkg::reg_idx_t rt_i;
	exec_pkg::reg_idx_t rd_i;
	alu_pkg::data_t     pc2_i;
	logic               busy_o;
	logic               done_o;
	alu_pkg::data_t     result_o;
	logic               zf_o;
	logic               lt_o;

	alu_pkg::data_t shadow [`REG_CNT]; // Expected register contents
	bit             fail_shown;
	bit             done_ok;

	exec_top u_dut (
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.load_i      (load_i),
		.load_addr_i (load_addr_i),
		.load_data_i (load_data_i),
		.start_i     (start_i),
		.op_i        (op_i),
		.rs_i        (rs_i),
		.rt_i        (rt_i),
		.rd_i        (rd_i),
		.pc2_i       (pc2_i),
		.busy_o      (busy_o),
		.done_o      (done_o),
		.result_o    (result_o),
		.zf_o        (zf_o),
		.lt_o        (lt_o)
	);

	bind exec_ctrl exec_chk u_chk (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.busy_i   (busy_o),
		.cap_i    (cap_o),
		.step_i   (step_o),
		.wb_i     (wb_o),
		.done_i   (done_o)
	);

	always #(CLK_HALF) clk = ~clk;

	task automatic report_failure(input string msg);
		fail_shown = 1'b1;
		$display("%s", msg);
		$display("SIMULATION FAILED");
		$fatal(1, "run stopped on first failure");
	endtask

	task automatic check_eq(input string name, input alu_pkg::data_t exp,
		input alu_pkg::data_t act);
		if (exp !== act) begin
			report_failure($sformatf("error %s expected %h actual %h", name, exp, act));
		end
	endtask

	function automatic logic is_shift_op(input alu_pkg::alu_op_t op);
		return (op >= `OP_ROL) && (op <= `OP_SRL);
	endfunction

	// Reference rules of the sixteen opcodes
	function automatic alu_pkg::data_t model_result(input alu_pkg::alu_op_t op,
		input alu_pkg::data_t a, input alu_pkg::data_t b, input alu_pkg::data_t pc2);
		int             n;
		logic [16:0]    wide;
		alu_pkg::data_t r;
		n    = int'(b[`SHAMT_W-1:0]);
		wide = {1'b0, a} + {1'b0, b}; // Top bit is the carry
		r    = '0;
		case (op)
			`OP_ADD:   r = a + b;
			`OP_SUB:   r = b - a;
			`OP_XOR:   r = a ^ b;
			`OP_ANDN:  r = a & ~b;
			`OP_ROL:   r = (a << n) | (a >> (`DATA_W - n)); // n of 0 leaves a
			`OP_SLL:   r = a << n;
			`OP_ROR:   r = (a >> n) | (a << (`DATA_W - n));
			`OP_SRL:   r = a >> n;
			`OP_SEQ:   r = 16'(a == b);
			`OP_SLT:   r = 16'($signed(a) < $signed(b));
			`OP_SLE:   r = 16'($signed(a) <= $signed(b));
			`OP_SCO:   r = 16'(wide[16]);
			`OP_BTR: begin
				for (int i = 0; i < `DATA_W; i++) begin
					r[i] = a[`DATA_W-1-i];
				end
			end
			`OP_PASSB: r = b;
			`OP_SLBI:  r = {a[7:0], b[7:0]};
			`OP_PC2:   r = pc2;
			default:   r = '0;
		endcase
		return r;
	endfunction

	function automatic logic expect_lt(input alu_pkg::alu_op_t op, input alu_pkg::data_t a,
		input alu_pkg::data_t b);
		if ((op == `OP_SLT) || (op == `OP_SLE)) begin
			return $signed(a) < $signed(b);
		end
		return 1'b0; // Flag only meaningful for the signed compares
	endfunction

	task automatic load_reg(input exec_pkg::reg_idx_t idx, input alu_pkg::data_t val);
		@(posedge clk);
		load_i      <= 1'b1;
		load_addr_i <= idx;
		load_data_i <= val;
		@(posedge clk);
		load_i      <= 1'b0;
		shadow[idx] = val;
	endtask

	// One operation end to end; inject pokes start and load while busy
	task automatic run_op(input string name, input alu_pkg::alu_op_t op,
		input exec_pkg::reg_idx_t rs, input exec_pkg::reg_idx_t rt,
		input exec_pkg::reg_idx_t rd, input bit inject);
		alu_pkg::data_t a;
		alu_pkg::data_t b;
		alu_pkg::data_t exp_res;
		logic           exp_lt;
		int             exp_lat;
		int             lat;
		a       = shadow[rs];
		b       = shadow[rt];
		exp_res = model_result(op, a, b, pc2_i);
		exp_lt  = expect_lt(op, a, b);
		exp_lat = is_shift_op(op) ? 1 + int'(b[`SHAMT_W-1:0]) : 1;
		@(posedge clk);
		start_i <= 1'b1;
		op_i    <= op;
		rs_i    <= rs;
		rt_i    <= rt;
		rd_i    <= rd;
		@(posedge clk);                           // Accepted on this edge
		start_i <= 1'b0;
		lat = 0;
		forever begin
			@(negedge clk);
			lat++;
			if (!busy_o) begin
				report_failure($sformatf("%s: busy_o went low before done_o", name));
			end
			if (done_o) begin
				break;
			end
			if (lat >= LAT_LIMIT) begin
				report_failure($sformatf("%s: done_o never came", name));
			end
			@(posedge clk);
			if (inject && (lat == 1)) begin
				start_i     <= 1'b1;              // Must be dropped
				op_i        <= `OP_ADD;
				load_i      <= 1'b1;              // Must be dropped too
				load_addr_i <= rs;
				load_data_i <= ~a;
			end else begin
				start_i <= 1'b0;
				load_i  <= 1'b0;
			end
		end
		check_eq($sformatf("%s result", name), exp_res, result_o);
		check_eq($sformatf("%s zf", name), 16'(exp_res == '0), 16'(zf_o));
		check_eq($sformatf("%s lt", name), 16'(exp_lt), 16'(lt_o));
		check_eq($sformatf("%s latency", name), 16'(exp_lat), 16'(lat));
		shadow[rd] = exp_res;                     // Write-back lands next edge
	endtask

	task automatic reset_readback;
		@(negedge clk);
		check_eq("reset busy", 16'h0, 16'(busy_o));
		check_eq("reset done", 16'h0, 16'(done_o));
		for (int r = 0; r < `REG_CNT; r++) begin
			run_op($sformatf("reset read r%0d", r), `OP_PASSB, 3'd0, 3'(r), 3'(r), 1'b0);
		end
	endtask

	task automatic arith_ops;
		exec_pkg::reg_idx_t rd;
		for (int round = 0; round < 4; round++) begin
			@(posedge clk);
			pc2_i <= 16'($urandom()); // Settles during the loads below
			for (int r = 0; r < `REG_CNT; r++) begin
				load_reg(3'(r), 16'($urandom()));
			end
			for (int k = 0; k < 8; k++) begin
				rd = 3'($urandom());
				run_op($sformatf("arith op %0h", ARITH_SEQ[4*k +: 4]), ARITH_SEQ[4*k +: 4],
					3'($urandom()), 3'($urandom()), rd, 1'b0);
			end
			run_op("arith readback", `OP_PASSB, 3'd0, rd, rd, 1'b0); // Last write-back
		end
	endtask

	task automatic cmp_pair(input alu_pkg::data_t a, input alu_pkg::data_t b);
		load_reg(3'd1, a);
		load_reg(3'd2, b);
		run_op($sformatf("seq %h %h", a, b), `OP_SEQ, 3'd1, 3'd2, 3'd3, 1'b0);
		run_op($sformatf("slt %h %h", a, b), `OP_SLT, 3'd1, 3'd2, 3'd3, 1'b0);
		run_op($sformatf("sle %h %h", a, b), `OP_SLE, 3'd1, 3'd2, 3'd3, 1'b0);
		run_op($sformatf("sco %h %h", a, b), `OP_SCO, 3'd1, 3'd2, 3'd3, 1'b0);
	endtask

	task automatic compare_ops;
		cmp_pair(16'h1234, 16'h1234);
		cmp_pair(16'h8000, 16'h0001); // Signs differ
		cmp_pair(16'h0001, 16'h8000);
		cmp_pair(16'hfffe, 16'hfffe);
		cmp_pair(16'h7fff, 16'h8000);
		cmp_pair(16'hffff, 16'h0001); // Carry out
		cmp_pair(16'($urandom()), 16'($urandom()));
	endtask

	task automatic shift_sweep;
		alu_pkg::data_t a;
		for (int m = 4; m <= 7; m++) begin
			a = 16'($urandom()) | 16'h8001;      // Both end bits set
			load_reg(3'd1, a);
			for (int c = 0; c < 16; c++) begin
				load_reg(3'd2, {12'($urandom()), 4'(c)}); // Upper B bits are noise
				run_op($sformatf("shift op %0d by %0d", m, c), 4'(m), 3'd1, 3'd2, 3'd3, 1'b0);
			end
		end
	endtask

	task automatic busy_drop;
		load_reg(3'd4, 16'hc3a5);
		load_reg(3'd5, 16'h0009);
		run_op("busy rol", `OP_ROL, 3'd4, 3'd5, 3'd6, 1'b1);
		repeat (2) begin
			@(negedge clk);
			check_eq("busy no restart", 16'h0, 16'(busy_o));
			check_eq("busy no extra done", 16'h0, 16'(done_o));
		end
		run_op("busy load dropped", `OP_PASSB, 3'd0, 3'd4, 3'd7, 1'b0);
	endtask

	task automatic zero_flag;
		load_reg(3'd1, 16'h1357);
		load_reg(3'd2, 16'h1357);
		run_op("zero xor", `OP_XOR, 3'd1, 3'd2, 3'd3, 1'b0);
		run_op("zero sub", `OP_SUB, 3'd1, 3'd2, 3'd3, 1'b0);
		run_op("zero andn", `OP_ANDN, 3'd1, 3'd2, 3'd3, 1'b0);
		run_op("nonzero add", `OP_ADD, 3'd1, 3'd2, 3'd3, 1'b0);
		load_reg(3'd2, 16'h1356);
		run_op("nonzero xor", `OP_XOR, 3'd1, 3'd2, 3'd3, 1'b0);
		run_op("nonzero sub", `OP_SUB, 3'd1, 3'd2, 3'd3, 1'b0);
	endtask

	initial begin
		void'($urandom(32'h5f2c_4b91));
		clk         = 1'b0;
		arst_n_i    = 1'b0;
		load_i      = 1'b0;
		load_addr_i = '0;
		load_data_i = '0;
		start_i     = 1'b0;
		op_i        = '0;
		rs_i        = '0;
		rt_i        = '0;
		rd_i        = '0;
		pc2_i       = 16'h0102;
		fail_shown  = 1'b0;
		done_ok     = 1'b0;
		for (int r = 0; r < `REG_CNT; r++) begin
			shadow[r] = '0; // Reset value of every register
		end
		repeat (3) @(posedge clk);
		arst_n_i <= 1'b1;
		reset_readback();
		arith_ops();
		compare_ops();
		shift_sweep();
		busy_drop();
		zero_flag();
		done_ok = 1'b1;
		$display("SIMULATION PASSED");
		$finish;
	end

	// Each operation gets a generous fixed number of cycles
	initial begin
		#(TOTAL_OPS * LAT_LIMIT * 2 * CLK_HALF);
		report_failure("watchdog timeout, the tests took longer than expected");
	end

	final begin
		if (!done_ok && !fail_shown) begin
			$display("SIMULATION FAILED"); // Stopped by an assertion
		end
	end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+.
alu_pkg.sv
exec_pkg.sv
alu_cla.sv
shift_counter.sv
alu_shifter.sv
alu.sv
reg_file.sv
exec_ctrl.sv
exec_top.sv
exec_chk.sv
tb_exec.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the execute unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module tb_exec -f flist.f -o tb_exec_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_exec_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulator exited with status $status"
fi

if grep -q "SIMULATION PASSED" "$LOG"; then
	exit 0
else
	exit 1
fi
